// File: hw/alu_config.svh
// ALU array configuration: lane count, queue depths and register map
`ifndef ALU_CONFIG_SVH
`define ALU_CONFIG_SVH

// Number of parallel ALU lanes
`define ALU_LANES 4

// Queue depths
`define CMD_DEPTH 8
`define RES_DEPTH 8

// AXI4-Lite register offsets
`define REG_OPND   4'h0
`define REG_CTRL   4'h4
`define REG_RESULT 4'h8
`define REG_STATUS 4'hC

`endif

// File: hw/aluPkg.sv
// ALU array types: operation codes, condition codes, command and result words
`default_nettype none

package aluPkg;

    // Compact local operation code
    typedef enum logic [4:0] {
        OP_LD,  OP_ADD, OP_ADC, OP_SUB, OP_SBC,
        OP_AND, OP_EOR, OP_OR,  OP_CMP, OP_CLR,
        OP_COM, OP_NEG, OP_INC, OP_DEC, OP_LSR,
        OP_ASR, OP_LSL, OP_ROL, OP_ROR
    } aluOp_e;

    typedef struct packed {
        logic h;    // Half carry
        logic n;    // Negative
        logic z;    // Zero
        logic v;    // Overflow
        logic c;    // Carry or borrow
    } ccFlags_t;

    typedef struct packed {
        aluOp_e      op;
        logic        wide;  // 16-bit operation when set
        ccFlags_t    ccIn;
        logic [15:0] opnd0;
        logic [15:0] opnd1;
    } aluCmd_t;

    typedef struct packed {
        logic [15:0] rslt;
        ccFlags_t    ccOut;
    } aluRes_t;

endpackage

`default_nettype wire

// File: hw/syncFifo.sv
// Synchronous FIFO with valid/ready on both sides, payload type set by parameter
`default_nettype none

module syncFifo #(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH     = 8
) (
    input  logic     clk,
    input  logic     rst,
    input  payload_t inData,
    input  logic     inValid,
    output logic     inReady,
    output payload_t outData,
    output logic     outValid,
    input  logic     outReady
);
    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    payload_t      mem [DEPTH];
    logic [AW-1:0] wrPtr;
    logic [AW-1:0] rdPtr;
    logic [AW:0]   count;
    logic          push;
    logic          pop;

    assign push     = inValid && inReady;
    assign pop      = outValid && outReady;
    assign inReady  = count != (AW+1)'(DEPTH);  // Not full
    assign outValid = count != '0;
    assign outData  = mem[rdPtr];

    always_ff @(posedge clk) begin
        if (push) mem[wrPtr] <= inData;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (push) wrPtr <= (wrPtr == AW'(DEPTH - 1)) ? '0 : wrPtr + 1'b1;
            if (pop) rdPtr <= (rdPtr == AW'(DEPTH - 1)) ? '0 : rdPtr + 1'b1;
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // Idle or simultaneous push and pop
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hw/aluCore.sv
// Combinational 8/16-bit ALU with 6809-style condition-code rules
`default_nettype none

module aluCore (
    input  aluPkg::aluCmd_t cmd,
    output aluPkg::aluRes_t res
);
    logic [3:0]       msbIdx;
    logic [4:0]       carryIdx;
    logic [15:0]      opA;
    logic [15:0]      opB;
    logic [15:0]      msbOnly;
    logic [15:0]      maxPos;
    logic             cIn;
    logic [16:0]      sum;
    logic [16:0]      diff;
    logic [15:0]      r;
    aluPkg::ccFlags_t cc;

    assign msbIdx   = cmd.wide ? 4'd15 : 4'd7;
    assign carryIdx = cmd.wide ? 5'd16 : 5'd8;
    assign opA      = cmd.wide ? cmd.opnd0 : {8'h00, cmd.opnd0[7:0]};
    assign opB      = cmd.wide ? cmd.opnd1 : {8'h00, cmd.opnd1[7:0]};
    assign msbOnly  = cmd.wide ? 16'h8000 : 16'h0080;  // Also the most negative value
    assign maxPos   = cmd.wide ? 16'h7FFF : 16'h007F;

    // Carry in only for the extended forms
    assign cIn  = cmd.ccIn.c && (cmd.op == aluPkg::OP_ADC || cmd.op == aluPkg::OP_SBC);
    assign sum  = {1'b0, opA} + {1'b0, opB} + {16'h0000, cIn};
    assign diff = {1'b0, opA} - {1'b0, opB} - {16'h0000, cIn};

    always_comb begin
        r  = opA;
        cc = cmd.ccIn;
        case (cmd.op)
            aluPkg::OP_LD: cc.v = 1'b0;
            aluPkg::OP_ADD, aluPkg::OP_ADC: begin
                r    = sum[15:0];
                cc.c = sum[carryIdx];
                cc.v = (opA[msbIdx] == opB[msbIdx]) && (sum[msbIdx] != opA[msbIdx]);
                if (!cmd.wide) cc.h = opA[4] ^ opB[4] ^ sum[4];  // Carry out of bit 3
            end
            aluPkg::OP_SUB, aluPkg::OP_SBC, aluPkg::OP_CMP: begin
                r    = diff[15:0];
                cc.c = diff[carryIdx];  // Borrow
                cc.v = (opA[msbIdx] != opB[msbIdx]) && (diff[msbIdx] != opA[msbIdx]);
            end
            aluPkg::OP_AND: begin
                r    = opA & opB;
                cc.v = 1'b0;
            end
            aluPkg::OP_EOR: begin
                r    = opA ^ opB;
                cc.v = 1'b0;
            end
            aluPkg::OP_OR: begin
                r    = opA | opB;
                cc.v = 1'b0;
            end
            aluPkg::OP_CLR: begin
                r    = 16'h0000;
                cc.c = 1'b0;
                cc.v = 1'b0;
            end
            aluPkg::OP_COM: begin
                r    = ~opA;
                cc.c = 1'b1;
                cc.v = 1'b0;
            end
            aluPkg::OP_NEG: begin
                r    = 16'h0000 - opA;
                cc.c = cmd.wide ? (r != 16'h0000) : (r[7:0] != 8'h00);
                cc.v = opA == msbOnly;
            end
            aluPkg::OP_INC: begin
                r    = opA + 16'h0001;
                cc.v = opA == maxPos;
            end
            aluPkg::OP_DEC: begin
                r    = opA - 16'h0001;
                cc.v = opA == msbOnly;
            end
            aluPkg::OP_LSR: begin
                r    = opA >> 1;
                cc.c = opA[0];
            end
            aluPkg::OP_ASR: begin
                r         = opA >> 1;
                r[msbIdx] = opA[msbIdx];  // Sign kept
                cc.c      = opA[0];
            end
            aluPkg::OP_LSL, aluPkg::OP_ROL: begin
                r    = {opA[14:0], cmd.op == aluPkg::OP_ROL && cmd.ccIn.c};
                cc.c = opA[msbIdx];
                cc.v = opA[msbIdx] ^ r[msbIdx];
            end
            aluPkg::OP_ROR: begin
                r         = opA >> 1;
                r[msbIdx] = cmd.ccIn.c;  // Old carry into msb
                cc.c      = opA[0];
            end
            default: r = opA;  // Unused codes pass opnd0 through
        endcase
        if (!cmd.wide) r[15:8] = 8'h00;
        cc.z = r == 16'h0000;
        cc.n = r[msbIdx];
    end

    assign res = {r, cc};

endmodule

`default_nettype wire

// File: hw/aluLane.sv
// Single-slot ALU lane holding one result until the collector takes it
`default_nettype none

module aluLane (
    input  logic            clk,
    input  logic            rst,
    input  aluPkg::aluCmd_t cmdIn,
    input  logic            cmdValid,
    output logic            cmdReady,
    output aluPkg::aluRes_t resOut,
    output logic            resValid,
    input  logic            resReady
);
    aluPkg::aluRes_t coreRes;
    logic            full;
    logic            accept;

    aluCore core (
        .cmd(cmdIn),
        .res(coreRes)
    );

    // Free slot, or the held result leaves this cycle
    assign cmdReady = !full || resReady;
    assign accept   = cmdValid && cmdReady;
    assign resValid = full;

    always_ff @(posedge clk) begin
        if (rst) full <= 1'b0;
        else if (accept) full <= 1'b1;
        else if (resReady) full <= 1'b0;
    end

    always_ff @(posedge clk) begin
        if (accept) resOut <= coreRes;
    end

endmodule

`default_nettype wire

// File: hw/laneDispatcher.sv
// Round-robin hand-off of queued commands to the ALU lanes
`include "alu_config.svh"
`default_nettype none

module laneDispatcher #(
    parameter int LANES = `ALU_LANES
) (
    input  logic             clk,
    input  logic             rst,
    input  aluPkg::aluCmd_t  cmdIn,
    input  logic             cmdValid,
    output logic             cmdReady,
    output aluPkg::aluCmd_t  laneCmd,
    output logic [LANES-1:0] laneValid,
    input  logic [LANES-1:0] laneReady
);
    localparam int PW = (LANES > 1) ? $clog2(LANES) : 1;

    logic [PW-1:0] ptr;

    assign laneCmd  = cmdIn;  // Shared bus, valid picks the lane
    assign cmdReady = laneReady[ptr];

    always_comb begin
        for (int i = 0; i < LANES; i++) laneValid[i] = cmdValid && (ptr == PW'(i));
    end

    always_ff @(posedge clk) begin
        if (rst) ptr <= '0;
        else if (cmdValid && cmdReady) ptr <= (ptr == PW'(LANES - 1)) ? '0 : ptr + 1'b1;
    end

endmodule

`default_nettype wire

// File: hw/resultCollector.sv
// In-order round-robin draining of lane results into the result queue
`include "alu_config.svh"
`default_nettype none

module resultCollector #(
    parameter int LANES = `ALU_LANES
) (
    input  logic             clk,
    input  logic             rst,
    input  aluPkg::aluRes_t  laneRes [LANES],
    input  logic [LANES-1:0] laneValid,
    output logic [LANES-1:0] laneReady,
    output aluPkg::aluRes_t  resOut,
    output logic             resValid,
    input  logic             resReady
);
    localparam int PW = (LANES > 1) ? $clog2(LANES) : 1;

    logic [PW-1:0] ptr;

    // Waits on the pointed lane even if others are done
    assign resOut   = laneRes[ptr];
    assign resValid = laneValid[ptr];

    always_comb begin
        for (int i = 0; i < LANES; i++) laneReady[i] = resReady && (ptr == PW'(i));
    end

    always_ff @(posedge clk) begin
        if (rst) ptr <= '0;
        else if (resValid && resReady) ptr <= (ptr == PW'(LANES - 1)) ? '0 : ptr + 1'b1;
    end

endmodule

`default_nettype wire

// File: hw/axilRegs.sv
// AXI4-Lite register slave that queues ALU commands and returns results
`include "alu_config.svh"
`default_nettype none

module axilRegs (
    input  logic            clk,
    input  logic            rst,
    input  logic [3:0]      awaddr,
    input  logic            awvalid,
    output logic            awready,
    input  logic [31:0]     wdata,
    input  logic            wvalid,
    output logic            wready,
    output logic [1:0]      bresp,
    output logic            bvalid,
    input  logic            bready,
    input  logic [3:0]      araddr,
    input  logic            arvalid,
    output logic            arready,
    output logic [31:0]     rdata,
    output logic [1:0]      rresp,
    output logic            rvalid,
    input  logic            rready,
    output aluPkg::aluCmd_t cmdOut,
    output logic            cmdValid,
    input  logic            cmdReady,
    input  aluPkg::aluRes_t resIn,
    input  logic            resValid,
    output logic            resReady
);
    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    logic [31:0] opndReg;  // opnd1 high, opnd0 low
    logic        wrXfer;
    logic        rdXfer;

    assign wready = awready;  // Address and data taken together
    assign wrXfer = awready && awvalid && wvalid;
    assign rdXfer = arready && arvalid;
    assign rresp  = RESP_OKAY;

    assign cmdOut = '{
        op:    aluPkg::aluOp_e'(wdata[4:0]),
        wide:  wdata[8],
        ccIn:  aluPkg::ccFlags_t'(wdata[20:16]),
        opnd0: opndReg[15:0],
        opnd1: opndReg[31:16]
    };
    assign cmdValid = wrXfer && (awaddr == `REG_CTRL);
    assign resReady = rdXfer && (araddr == `REG_RESULT);  // Pops only if non-empty

    always_ff @(posedge clk) begin
        if (rst) begin
            awready <= 1'b0;
            bvalid  <= 1'b0;
        end else begin
            awready <= !awready && !bvalid && awvalid && wvalid;  // One-cycle pulse
            if (wrXfer) bvalid <= 1'b1;
            else if (bready) bvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (wrXfer) begin
            if (awaddr == `REG_OPND) opndReg <= wdata;
            bresp <= (cmdValid && !cmdReady) ? RESP_SLVERR : RESP_OKAY;  // Queue full
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            arready <= 1'b0;
            rvalid  <= 1'b0;
        end else begin
            arready <= !arready && !rvalid && arvalid;
            if (rdXfer) rvalid <= 1'b1;
            else if (rready) rvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rdXfer) begin
            case (araddr)
                `REG_RESULT: rdata <= resValid ? {1'b1, 10'h000, resIn.ccOut, resIn.rslt} : '0;
                `REG_STATUS: rdata <= {30'h0, resValid, !cmdReady};
                default:     rdata <= '0;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hw/aluArrayTop.sv
// ALU array top: register slave, command and result queues, lanes and routing
`include "alu_config.svh"
`default_nettype none

module aluArrayTop (
    input  logic        clk,
    input  logic        rst,
    input  logic [3:0]  awaddr,
    input  logic        awvalid,
    output logic        awready,
    input  logic [31:0] wdata,
    input  logic        wvalid,
    output logic        wready,
    output logic [1:0]  bresp,
    output logic        bvalid,
    input  logic        bready,
    input  logic [3:0]  araddr,
    input  logic        arvalid,
    output logic        arready,
    output logic [31:0] rdata,
    output logic [1:0]  rresp,
    output logic        rvalid,
    input  logic        rready
);
    localparam int LANES = `ALU_LANES;

    aluPkg::aluCmd_t  regCmd;
    logic             regCmdValid;
    logic             regCmdReady;
    aluPkg::aluCmd_t  qCmd;
    logic             qCmdValid;
    logic             qCmdReady;
    aluPkg::aluCmd_t  laneCmd;
    logic [LANES-1:0] laneCmdValid;
    logic [LANES-1:0] laneCmdReady;
    aluPkg::aluRes_t  laneRes [LANES];
    logic [LANES-1:0] laneResValid;
    logic [LANES-1:0] laneResReady;
    aluPkg::aluRes_t  colRes;
    logic             colResValid;
    logic             colResReady;
    aluPkg::aluRes_t  qRes;
    logic             qResValid;
    logic             qResReady;

    axilRegs regs (
        .clk(clk), .rst(rst),
        .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
        .wdata(wdata), .wvalid(wvalid), .wready(wready),
        .bresp(bresp), .bvalid(bvalid), .bready(bready),
        .araddr(araddr), .arvalid(arvalid), .arready(arready),
        .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
        .cmdOut(regCmd), .cmdValid(regCmdValid), .cmdReady(regCmdReady),
        .resIn(qRes), .resValid(qResValid), .resReady(qResReady)
    );

    syncFifo #(.payload_t(aluPkg::aluCmd_t), .DEPTH(`CMD_DEPTH)) cmdFifo (
        .clk(clk), .rst(rst),
        .inData(regCmd), .inValid(regCmdValid), .inReady(regCmdReady),
        .outData(qCmd), .outValid(qCmdValid), .outReady(qCmdReady)
    );

    laneDispatcher #(.LANES(LANES)) dispatcher (
        .clk(clk), .rst(rst),
        .cmdIn(qCmd), .cmdValid(qCmdValid), .cmdReady(qCmdReady),
        .laneCmd(laneCmd), .laneValid(laneCmdValid), .laneReady(laneCmdReady)
    );

    for (genvar i = 0; i < LANES; i++) begin : genLane
        aluLane lane (
            .clk(clk), .rst(rst),
            .cmdIn(laneCmd), .cmdValid(laneCmdValid[i]), .cmdReady(laneCmdReady[i]),
            .resOut(laneRes[i]), .resValid(laneResValid[i]), .resReady(laneResReady[i])
        );
    end

    resultCollector #(.LANES(LANES)) collector (
        .clk(clk), .rst(rst),
        .laneRes(laneRes), .laneValid(laneResValid), .laneReady(laneResReady),
        .resOut(colRes), .resValid(colResValid), .resReady(colResReady)
    );

    syncFifo #(.payload_t(aluPkg::aluRes_t), .DEPTH(`RES_DEPTH)) resFifo (
        .clk(clk), .rst(rst),
        .inData(colRes), .inValid(colResValid), .inReady(colResReady),
        .outData(qRes), .outValid(qResValid), .outReady(qResReady)
    );

endmodule

`default_nettype wire

// File: verif/clockGen.sv
// Testbench clock and reset source: 20 ns clock, reset held for 16 cycles
`default_nettype none

module clockGen (
    output logic clk,
    output logic rst
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;  // 20 ns period
    end

    initial begin
        rst = 1'b1;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

`default_nettype wire

// File: verif/tbAluArray.sv
// ALU array testbench: random AXI4-Lite commands checked against a reference ALU model
`include "alu_config.svh"
`default_nettype none

module tbAluArray;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_DIRECTED = 19 * 2 * 3;
    localparam int NUM_RANDOM   = 300;
    localparam int BP_TRIES     = `CMD_DEPTH + `RES_DEPTH + `ALU_LANES + 2;
    localparam int NUM_TXN      = (NUM_DIRECTED + NUM_RANDOM) * 4 + `CMD_DEPTH * 3
                                  + BP_TRIES * 3 + 10;
    localparam int CYCLE_LIMIT  = NUM_TXN * 20 + 200;

    logic clk, rst;
    logic [3:0] awaddr, araddr;
    logic [31:0] wdata, rdata;
    logic awvalid, awready, wvalid, wready, bvalid, bready;
    logic arvalid, arready, rvalid, rready;
    logic [1:0] bresp, rresp;
    int errors = 0;
    int checks = 0;
    int unsigned cycles = 0;
    aluPkg::aluRes_t expQ[$];

    clockGen clkGen (.clk(clk), .rst(rst));
    aluArrayTop dut (.*);

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: run exceeded %0d cycles", CYCLE_LIMIT);
            $display("Checks failed");
            $finish;
        end
    end

    // Reference ALU written from the condition-code rules
    function automatic aluPkg::aluRes_t refAlu(input aluPkg::aluCmd_t cmd);
        int w, mask, msb, a, b, r, cin;
        aluPkg::ccFlags_t f;
        aluPkg::aluRes_t res;
        w = cmd.wide ? 16 : 8;
        mask = (1 << w) - 1;
        msb = 1 << (w - 1);
        a = int'(cmd.opnd0) & mask;
        b = int'(cmd.opnd1) & mask;
        cin = ((cmd.op == aluPkg::OP_ADC || cmd.op == aluPkg::OP_SBC) && cmd.ccIn.c) ? 1 : 0;
        f = cmd.ccIn;
        r = a;
        case (cmd.op)
            aluPkg::OP_LD: f.v = 1'b0;
            aluPkg::OP_ADD, aluPkg::OP_ADC: begin
                r = a + b + cin;
                f.c = r > mask;
                f.v = (((a ^ b) & msb) == 0) && (((a ^ r) & msb) != 0);
                if (!cmd.wide) f.h = ((a & 15) + (b & 15) + cin) > 15;
            end
            aluPkg::OP_SUB, aluPkg::OP_SBC, aluPkg::OP_CMP: begin
                r = a - b - cin;
                f.c = r < 0;  // Borrow
                f.v = (((a ^ b) & msb) != 0) && (((a ^ r) & msb) != 0);
            end
            aluPkg::OP_AND: begin
                r = a & b;
                f.v = 1'b0;
            end
            aluPkg::OP_EOR: begin
                r = a ^ b;
                f.v = 1'b0;
            end
            aluPkg::OP_OR: begin
                r = a | b;
                f.v = 1'b0;
            end
            aluPkg::OP_CLR: begin
                r = 0;
                f.c = 1'b0;
                f.v = 1'b0;
            end
            aluPkg::OP_COM: begin
                r = ~a;
                f.c = 1'b1;
                f.v = 1'b0;
            end
            aluPkg::OP_NEG: begin
                r = (-a) & mask;
                f.c = r != 0;
                f.v = a == msb;
            end
            aluPkg::OP_INC: begin
                r = a + 1;
                f.v = a == msb - 1;
            end
            aluPkg::OP_DEC: begin
                r = a - 1;
                f.v = a == msb;
            end
            aluPkg::OP_LSR: begin
                r = a >> 1;
                f.c = a[0];
            end
            aluPkg::OP_ASR: begin
                r = (a >> 1) | (a & msb);
                f.c = a[0];
            end
            aluPkg::OP_LSL, aluPkg::OP_ROL: begin
                r = (a << 1) | ((cmd.op == aluPkg::OP_ROL) ? int'(cmd.ccIn.c) : 0);
                f.c = (a & msb) != 0;
                f.v = ((a & msb) != 0) != ((r & msb) != 0);
            end
            aluPkg::OP_ROR: begin
                r = (a >> 1) | (cmd.ccIn.c ? msb : 0);
                f.c = a[0];
            end
            default: r = a;
        endcase
        r = r & mask;
        f.z = r == 0;
        f.n = (r & msb) != 0;
        res.rslt = 16'(r);
        res.ccOut = f;
        return res;
    endfunction

    function automatic logic [31:0] expWord(input aluPkg::aluRes_t res);
        logic [31:0] w;
        w = '0;
        w[31] = 1'b1;  // Valid bit
        w[20:16] = res.ccOut;
        w[15:0] = res.rslt;
        return w;
    endfunction

    function automatic logic [31:0] ctrlWord(input aluPkg::aluCmd_t cmd);
        logic [31:0] w;
        w = '0;
        w[4:0] = cmd.op;
        w[8] = cmd.wide;
        w[20:16] = cmd.ccIn;
        return w;
    endfunction

    function automatic aluPkg::aluCmd_t randomCmd();
        aluPkg::aluCmd_t cmd;
        cmd.op = aluPkg::aluOp_e'(5'($urandom_range(18, 0)));
        cmd.wide = 1'($urandom);
        cmd.ccIn = 5'($urandom);
        cmd.opnd0 = 16'($urandom);
        cmd.opnd1 = 16'($urandom);
        return cmd;
    endfunction

    task automatic checkWord(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic writeReg(input logic [3:0] addr, input logic [31:0] data,
                            output logic [1:0] resp);
        int waitCnt;
        waitCnt = 0;
        resp = 2'b00;
        @(posedge clk);
        awaddr <= addr;
        wdata <= data;
        awvalid <= 1'b1;
        wvalid <= 1'b1;
        @(negedge clk);
        while (!(awready && wready) && waitCnt < 50) begin
            waitCnt++;
            @(negedge clk);
        end
        @(posedge clk);
        awvalid <= 1'b0;
        wvalid <= 1'b0;
        bready <= 1'b1;
        @(negedge clk);
        while (!bvalid && waitCnt < 50) begin
            waitCnt++;
            @(negedge clk);
        end
        if (waitCnt >= 50) begin
            errors++;
            $display("Write to offset %h got no handshake or no response", addr);
        end
        resp = bresp;
        @(posedge clk);
        bready <= 1'b0;
    endtask

    task automatic readReg(input logic [3:0] addr, output logic [31:0] data);
        int waitCnt;
        waitCnt = 0;
        @(posedge clk);
        araddr <= addr;
        arvalid <= 1'b1;
        @(negedge clk);
        while (!arready && waitCnt < 50) begin
            waitCnt++;
            @(negedge clk);
        end
        @(posedge clk);
        arvalid <= 1'b0;
        rready <= 1'b1;
        @(negedge clk);
        while (!rvalid && waitCnt < 50) begin
            waitCnt++;
            @(negedge clk);
        end
        if (waitCnt >= 50) begin
            errors++;
            $display("Read of offset %h got no handshake or no data", addr);
        end
        data = rdata;
        checkWord($sformatf("read response offset %h", addr), 32'h0, 32'(rresp));
        @(posedge clk);
        rready <= 1'b0;
    endtask

    task automatic sendCmd(input aluPkg::aluCmd_t cmd, output logic [1:0] resp);
        logic [1:0] opndResp;
        writeReg(`REG_OPND, {cmd.opnd1, cmd.opnd0}, opndResp);
        checkWord("operand write response", 32'h0, 32'(opndResp));
        writeReg(`REG_CTRL, ctrlWord(cmd), resp);
    endtask

    // Polls status until a result is queued
    task automatic waitResult(output logic ready);
        logic [31:0] st;
        int polls;
        ready = 1'b0;
        polls = 0;
        while (!ready && polls < 40) begin
            readReg(`REG_STATUS, st);
            ready = st[1];
            polls++;
        end
        if (!ready) begin
            errors++;
            $display("Result never became available after %0d status polls", polls);
        end
    endtask

    task automatic runSingle(input string name, input aluPkg::aluCmd_t cmd);
        logic [1:0] resp;
        logic [31:0] data;
        logic ready;
        sendCmd(cmd, resp);
        checkWord({name, " write response"}, 32'h0, 32'(resp));
        waitResult(ready);
        if (ready) begin
            readReg(`REG_RESULT, data);
            checkWord(name, expWord(refAlu(cmd)), data);
        end
    endtask

    initial begin
        aluPkg::aluCmd_t cmd;
        logic [1:0] resp;
        logic [31:0] data;
        logic ready;
        logic rejected;
        int accepted;
        void'($urandom(32'h268e124c));
        awaddr = '0;
        awvalid = 1'b0;
        wdata = '0;
        wvalid = 1'b0;
        bready = 1'b0;
        araddr = '0;
        arvalid = 1'b0;
        rready = 1'b0;
        while (rst !== 1'b0) @(posedge clk);

        readReg(`REG_STATUS, data);
        checkWord("status after reset", 32'h0, data);
        readReg(`REG_RESULT, data);
        checkWord("empty result read", 32'h0, data);

        for (int op = 0; op < 19; op++) begin
            for (int w = 0; w < 2; w++) begin
                for (int k = 0; k < 3; k++) begin
                    cmd.op = aluPkg::aluOp_e'(5'(op));
                    cmd.wide = 1'(w);
                    cmd.ccIn = (k == 1) ? 5'h00 : 5'h1F;  // Carry in set on edge pairs
                    case (k)
                        0: cmd.opnd0 = w ? 16'h7FFF : 16'hA57F;  // Max positive
                        1: cmd.opnd0 = 16'h0000;
                        default: cmd.opnd0 = w ? 16'h8000 : 16'h5A80;  // Msb only
                    endcase
                    cmd.opnd1 = (k == 2) ? cmd.opnd0 : 16'h0001;
                    runSingle($sformatf("directed op %0d wide %0d case %0d", op, w, k), cmd);
                end
            end
        end

        for (int i = 0; i < NUM_RANDOM; i++) runSingle($sformatf("random %0d", i), randomCmd());

        for (int i = 0; i < `CMD_DEPTH; i++) begin
            cmd = randomCmd();
            sendCmd(cmd, resp);
            checkWord("burst write response", 32'h0, 32'(resp));
            expQ.push_back(refAlu(cmd));
        end
        while (expQ.size() > 0) begin
            waitResult(ready);
            readReg(`REG_RESULT, data);
            checkWord("burst order", expWord(expQ.pop_front()), data);
        end

        // Fill everything with no reads until a control write is refused
        accepted = 0;
        rejected = 1'b0;
        for (int i = 0; i < BP_TRIES && !rejected; i++) begin
            cmd = randomCmd();
            sendCmd(cmd, resp);
            if (resp == 2'b00) begin
                accepted++;
                expQ.push_back(refAlu(cmd));
            end else begin
                rejected = 1'b1;
                checkWord("rejected write response", 32'h2, 32'(resp));
            end
        end
        if (!rejected) begin
            errors++;
            $display("Back-pressure never produced an error response");
        end
        if (accepted < `CMD_DEPTH || accepted > `CMD_DEPTH + `RES_DEPTH + `ALU_LANES) begin
            errors++;
            $display("Back-pressure accepted %0d writes, outside the allowed range", accepted);
        end
        readReg(`REG_STATUS, data);
        checkWord("status when full", 32'h3, data);
        while (expQ.size() > 0) begin
            waitResult(ready);
            readReg(`REG_RESULT, data);
            checkWord("back-pressure order", expWord(expQ.pop_front()), data);
        end
        repeat (10) @(posedge clk);
        readReg(`REG_RESULT, data);
        checkWord("no result for rejected write", 32'h0, data);

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) $display("All checks passed");
        else $display("Checks failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: list.f
+incdir+hw
hw/aluPkg.sv
hw/syncFifo.sv
hw/aluCore.sv
hw/aluLane.sv
hw/laneDispatcher.sv
hw/resultCollector.sv
hw/axilRegs.sv
hw/aluArrayTop.sv
verif/clockGen.sv
verif/tbAluArray.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the ALU array simulation with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary -f list.f --top-module tbAluArray -o simAluArray
./obj_dir/simAluArray | tee sim.log

if grep -q "Checks failed" sim.log; then
    echo "Simulation reported failures"
    exit 1
fi
echo "Simulation finished without failures"
